// ==== files.f ====
spy_cmd_pkg.sv
spy_uart_pkg.sv
spy_uart_rx.sv
spy_cmd_engine.sv
spy_resp_tx.sv
spy_port_top.sv
spy_port_chk.sv
tb_spy_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the spy port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_spy_port -f files.f -o sim_spy_port
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# keep running after assertion errors so the testbench can count them
sim_out=$(./obj_dir/sim_spy_port +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

// ==== tb_spy_port.sv ====
// Spy port testbench with 0 to 3 ack wait states. The run stops after 60000 cycles.
`timescale 1ns/100ps
module tb_spy_port;
   localparam int BITC = spy_uart_pkg::BIT_CYCLES;
   localparam int MAX_CYCLES = 60000;  // ~120 bytes and 20 answers at 160 cycles with margin

   logic        spy_clk = 1'b0;
   logic        spy_reset = 1'b1;
   logic        rxd = 1'b1;
   logic        wb_ack = 1'b0;
   logic [15:0] wb_rdata = '0;
   logic        txd;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [4:0]  wb_adr;
   logic [15:0] wb_wdata;
   logic [15:0] mem [0:31];       // target model
   logic [15:0] exp_mem [0:31];   // contents the commands should leave
   logic [15:0] exp_vals [0:63];  // expected answers in order
   logic [31:0] rng = 32'h5e8c;
   logic [4:0]  last_adr;
   int cycles = 0;
   int errors = 0;
   int bus_cnt = 0;
   int exp_bus = 0;
   int reads_sent = 0;
   int resp_done = 0;
   int txd_falls = 0;
   int overlaps = 0;
   int passed = 0;
   int failed = 0;

   spy_port_top dut0 (.*);

   always #50 spy_clk = ~spy_clk;

   always @(posedge spy_clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   always @(negedge txd)
      txd_falls++;

   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [15:0] fill_word(input int a);
      return 16'hc0de ^ 16'(a * 16'h0b05);
   endfunction

   function automatic int total_errors();
      return errors + dut0.eng0.chk0.fail_cnt;
   endfunction

   task automatic check_value(input string name, input logic [15:0] exp_v, input logic [15:0] got);
      assert (got === exp_v)
      else
      begin
         $display("MISMATCH at %0d ns: %s expected %0h got %0h", $time, name, exp_v, got);
         errors++;
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      assert (ok)
      else
      begin
         $display("ERROR at %0d ns: %s", $time, what);
         errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge spy_clk);
      #10;
   endtask

   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      wait (reads_sent - resp_done <= 1);  // rx holds one byte while an answer drains
      next_cycle();
      for (int i = 0; i < 10; i++)
      begin
         rxd = frame[i];
         repeat (BITC) next_cycle();
      end
   endtask

   task automatic send_cmd(input logic [3:0] op, input logic [3:0] arg);
      send_byte({op, arg});
   endtask

   task automatic write_word(input logic hi, input logic [3:0] a, input logic [15:0] v);
      send_cmd(spy_cmd_pkg::OP_LD3, v[15:12]);
      send_cmd(spy_cmd_pkg::OP_LD2, v[11:8]);
      send_cmd(spy_cmd_pkg::OP_LD1, v[7:4]);
      send_cmd(spy_cmd_pkg::OP_LD0, v[3:0]);
      send_cmd(hi ? spy_cmd_pkg::OP_WR_HI : spy_cmd_pkg::OP_WR_LO, a);
      exp_mem[{hi, a}] = v;
      exp_bus++;
   endtask

   task automatic read_word(input logic hi, input logic [3:0] a);
      if (reads_sent != resp_done)
         overlaps++;  // previous answer still outstanding
      exp_vals[reads_sent] = exp_mem[{hi, a}];
      send_cmd(hi ? spy_cmd_pkg::OP_RD_HI : spy_cmd_pkg::OP_RD_LO, a);
      reads_sent++;
      exp_bus++;
   endtask

   task automatic drain();
      wait (bus_cnt == exp_bus && resp_done == reads_sent);
      next_cycle();
   endtask

   task automatic idle_window(input int n);
      repeat (n)
      begin
         next_cycle();
         check_true(txd === 1'b1 && wb_cyc === 1'b0, "txd low or bus cycle open while idle");
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      if (total_errors() == err_before)
      begin
         $display("test %s: pass", name);
         passed++;
      end
      else
      begin
         $display("test %s: FAIL with %0d errors", name, total_errors() - err_before);
         failed++;
      end
   endtask

   // four framed bytes from txd with the first byte on top
   task automatic get_resp(output logic [31:0] resp);
      logic [7:0] b;
      resp = '0;
      for (int k = 0; k < 4; k++)
      begin
         @(negedge txd);
         repeat (BITC / 2) @(negedge spy_clk);  // mid start bit
         for (int i = 0; i < 8; i++)
         begin
            repeat (BITC) @(negedge spy_clk);
            b[i] = txd;
         end
         repeat (BITC) @(negedge spy_clk);
         check_true(txd === 1'b1, "stop bit on txd is low");
         resp = {resp[23:0], b};
      end
   endtask

   initial
   begin
      logic [31:0] got;
      logic [15:0] v;
      forever
      begin
         get_resp(got);
         check_true(resp_done < reads_sent, "answer on txd without a pending read");
         v = exp_vals[resp_done];
         for (int k = 0; k < 4; k++)
            check_value("txd byte", 16'({4'(3 + k), v[15 - 4 * k -: 4]}),
                        16'(got[31 - 8 * k -: 8]));
         resp_done++;
      end
   end

   // wishbone target
   initial
   begin
      int waits;
      for (int i = 0; i < 32; i++)
         mem[i] = fill_word(i);
      forever
      begin
         next_cycle();
         if (wb_stb)
         begin
            waits = int'(next_random() % 32'd4);
            repeat (waits) next_cycle();
            last_adr = wb_adr;
            wb_rdata = mem[wb_adr];
            if (wb_we)
               mem[wb_adr] = wb_wdata;
            wb_ack = 1'b1;
            bus_cnt++;
            next_cycle();
            wb_ack = 1'b0;
         end
      end
   end

   initial
   begin
      int e;
      int falls;
      logic [31:0] r;
      for (int i = 0; i < 32; i++)
         exp_mem[i] = fill_word(i);
      repeat (5) @(posedge spy_clk);
      #10;
      spy_reset = 1'b0;

      e = total_errors();
      idle_window(200);
      check_true(bus_cnt == 0 && txd_falls == 0, "bus or txd activity after reset");
      end_test("reset state", e);

      e = total_errors();
      write_word(1'b0, 4'd5, 16'hb3e7);
      drain();
      check_value("mem[5]", 16'hb3e7, mem[5]);
      read_word(1'b0, 4'd5);
      drain();
      end_test("write and read back", e);

      e = total_errors();
      write_word(1'b1, 4'd2, 16'h4c19);
      drain();
      check_value("wb_adr", 16'd18, 16'(last_adr));
      check_value("mem[18]", 16'h4c19, mem[18]);
      check_value("mem[2]", fill_word(2), mem[2]);
      read_word(1'b1, 4'd2);
      drain();
      end_test("high bank", e);

      e = total_errors();
      falls = txd_falls;
      for (int i = 0; i < 16; i++)
         if (i < 3 || i == 7 || i > 11)
            send_byte({4'(i), 4'(i ^ 5)});
      idle_window(100);
      check_true(bus_cnt == exp_bus && txd_falls == falls, "ignored opcode caused activity");
      send_cmd(spy_cmd_pkg::OP_WR_LO, 4'd9);  // data register still holds 4c19
      exp_mem[9] = 16'h4c19;
      exp_bus++;
      drain();
      check_value("mem[9]", 16'h4c19, mem[9]);
      end_test("ignored opcodes", e);

      e = total_errors();
      for (int i = 0; i < 20; i++)
      begin
         r = next_random();
         if (r[9:8] == 2'b00)
            write_word(r[4], r[3:0], r[31:16]);
         else
            read_word(r[4], r[3:0]);
      end
      drain();
      check_true(overlaps > 0, "no read was sent while an answer was outstanding");
      for (int i = 0; i < 32; i++)
         check_value($sformatf("mem[%0d]", i), exp_mem[i], mem[i]);
      end_test("random traffic", e);

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errors());
      if (failed == 0 && total_errors() == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== spy_port_chk.sv ====
// Wishbone and answer handshake assertions bound into the command engine, active only with assertions on.
`timescale 1ns/100ps
module spy_port_chk (
   input logic                           spy_clk,
   input logic                           spy_reset,
   input logic                           rx_valid,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_we,
   input logic [spy_cmd_pkg::ADDR_W-1:0] wb_adr,
   input logic [spy_cmd_pkg::DATA_W-1:0] wb_wdata,
   input logic                           wb_ack,
   input logic                           resp_start,
   input logic                           tx_busy
);
   int fail_cnt = 0;
   logic seen_rx;  // a byte has arrived since reset

   always_ff @(posedge spy_clk)
      if (spy_reset)
         seen_rx <= 1'b0;
      else if (rx_valid)
         seen_rx <= 1'b1;

   a_stb_cyc: assert property (@(posedge spy_clk) disable iff (spy_reset) wb_stb |-> wb_cyc)
   else
   begin
      $error("wb_stb high without wb_cyc");
      fail_cnt++;
   end

   a_stable: assert property (@(posedge spy_clk) disable iff (spy_reset)
      wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
   else
   begin
      $error("address, we or data changed while waiting for ack");
      fail_cnt++;
   end

   a_cyc_drop: assert property (@(posedge spy_clk) disable iff (spy_reset)
      wb_cyc && wb_ack |=> !wb_cyc)
   else
   begin
      $error("wb_cyc still high in the cycle after ack");
      fail_cnt++;
   end

   a_start_busy: assert property (@(posedge spy_clk) disable iff (spy_reset)
      resp_start |-> !tx_busy)
   else
   begin
      $error("resp_start while the transmitter is busy");
      fail_cnt++;
   end

   a_quiet: assert property (@(posedge spy_clk) disable iff (spy_reset)
      !seen_rx |-> !wb_cyc && !resp_start)
   else
   begin
      $error("bus cycle or answer before any received byte");
      fail_cnt++;
   end

endmodule

bind spy_cmd_engine spy_port_chk chk0 (
   .spy_clk(spy_clk), .spy_reset(spy_reset), .rx_valid(rx_valid),
   .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
   .wb_wdata(wb_wdata), .wb_ack(wb_ack), .resp_start(resp_start), .tx_busy(tx_busy)
);

// ==== spy_port_top.sv ====
// Serial spy port top. rxd is asynchronous and everything else runs on spy_clk.
`timescale 1ns/100ps
module spy_port_top (
   input  logic        spy_clk,
   input  logic        spy_reset,
   input  logic        rxd,
   output logic        txd,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [4:0]  wb_adr,
   output logic [15:0] wb_wdata,
   input  logic [15:0] wb_rdata,
   input  logic        wb_ack
);
   logic [7:0]  rx_byte;
   logic        rx_valid;
   logic        rx_ready;
   logic [15:0] resp_value;
   logic        resp_start;
   logic        tx_busy;

   spy_uart_rx rx0 (
      .spy_clk(spy_clk), .spy_reset(spy_reset), .rxd(rxd),
      .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_ready(rx_ready)
   );

   spy_cmd_engine eng0 (
      .spy_clk(spy_clk), .spy_reset(spy_reset),
      .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_ready(rx_ready),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
      .resp_value(resp_value), .resp_start(resp_start), .tx_busy(tx_busy)
   );

   spy_resp_tx tx0 (
      .spy_clk(spy_clk), .spy_reset(spy_reset),
      .resp_value(resp_value), .resp_start(resp_start),
      .tx_busy(tx_busy), .txd(txd)
   );

endmodule

// ==== spy_resp_tx.sv ====
// Sends a read value as four 8N1 bytes tagged 3 to 6. resp_start is ignored while tx_busy is high.
`timescale 1ns/100ps
module spy_resp_tx (
   input  logic        spy_clk,
   input  logic        spy_reset,
   input  logic [15:0] resp_value,
   input  logic        resp_start,
   output logic        tx_busy,
   output logic        txd
);
   spy_uart_pkg::uart_state_e state;
   logic [spy_uart_pkg::CNT_W-1:0] cnt;
   logic [2:0] bit_idx;
   logic [1:0] byte_idx;
   logic [15:0] value_q;
   logic [3:0] nibble;
   logic [7:0] tx_byte;
   logic bit_end;

   assign bit_end = (cnt == spy_uart_pkg::BIT_LAST);
   assign tx_busy = (state != spy_uart_pkg::U_IDLE);

   always_comb
      case (byte_idx)
         2'd0:    nibble = value_q[15:12];  // msb first
         2'd1:    nibble = value_q[11:8];
         2'd2:    nibble = value_q[7:4];
         default: nibble = value_q[3:0];
      endcase

   assign tx_byte = {4'h3 + {2'b00, byte_idx}, nibble};

   always_ff @(posedge spy_clk)
      if (spy_reset)
      begin
         state    <= spy_uart_pkg::U_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
         byte_idx <= '0;
         txd      <= 1'b1;
      end
      else
      begin
         cnt <= bit_end ? '0 : cnt + 1'b1;
         case (state)
            spy_uart_pkg::U_IDLE:
            begin
               cnt <= '0;
               if (resp_start)
               begin
                  byte_idx <= '0;
                  txd      <= 1'b0;  // first start bit
                  state    <= spy_uart_pkg::U_START;
               end
            end
            spy_uart_pkg::U_START:
               if (bit_end)
               begin
                  bit_idx <= '0;
                  txd     <= tx_byte[0];
                  state   <= spy_uart_pkg::U_DATA;
               end
            spy_uart_pkg::U_DATA:
               if (bit_end)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                  begin
                     txd   <= 1'b1;
                     state <= spy_uart_pkg::U_STOP;
                  end
                  else
                     txd <= tx_byte[bit_idx + 3'd1];
               end
            default:
               if (bit_end)
               begin
                  if (byte_idx == 2'd3)
                     state <= spy_uart_pkg::U_IDLE;  // drops tx_busy
                  else
                  begin
                     byte_idx <= byte_idx + 1'b1;
                     txd      <= 1'b0;  // next byte back to back
                     state    <= spy_uart_pkg::U_START;
                  end
               end
         endcase
      end

   always_ff @(posedge spy_clk)
      if (state == spy_uart_pkg::U_IDLE && resp_start)
         value_q <= resp_value;

endmodule

// ==== spy_cmd_engine.sv ====
// Single byte command decoder and wishbone classic master. Only one bus cycle or response is in flight.
`timescale 1ns/100ps
module spy_cmd_engine (
   input  logic                           spy_clk,
   input  logic                           spy_reset,
   input  logic [7:0]                     rx_byte,
   input  logic                           rx_valid,
   output logic                           rx_ready,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic                           wb_we,
   output logic [spy_cmd_pkg::ADDR_W-1:0] wb_adr,
   output logic [spy_cmd_pkg::DATA_W-1:0] wb_wdata,
   input  logic [spy_cmd_pkg::DATA_W-1:0] wb_rdata,
   input  logic                           wb_ack,
   output logic [spy_cmd_pkg::DATA_W-1:0] resp_value,
   output logic                           resp_start,
   input  logic                           tx_busy
);
   spy_cmd_pkg::engine_state_e state;
   spy_cmd_pkg::spy_opcode_e opcode;
   logic [7:0] cmd_byte;
   logic [spy_cmd_pkg::DATA_W-1:0] data_reg;
   logic [spy_cmd_pkg::DATA_W-1:0] rd_data;
   logic is_write;

   assign opcode   = spy_cmd_pkg::spy_opcode_e'(cmd_byte[7:4]);
   assign is_write = (opcode == spy_cmd_pkg::OP_WR_LO) || (opcode == spy_cmd_pkg::OP_WR_HI);
   assign rx_ready = (state == spy_cmd_pkg::IDLE);
   assign wb_wdata = data_reg;  // only loaded in DECODE so stable over the bus cycle

   always_ff @(posedge spy_clk)
      if (spy_reset)
      begin
         state      <= spy_cmd_pkg::IDLE;
         data_reg   <= '0;
         wb_adr     <= '0;
         wb_cyc     <= 1'b0;
         wb_stb     <= 1'b0;
         wb_we      <= 1'b0;
         resp_start <= 1'b0;
      end
      else
      begin
         resp_start <= 1'b0;
         case (state)
            spy_cmd_pkg::IDLE:
               if (rx_valid)
                  state <= spy_cmd_pkg::DECODE;
            spy_cmd_pkg::DECODE:
            begin
               state <= spy_cmd_pkg::IDLE;
               case (opcode)
                  spy_cmd_pkg::OP_LD3: data_reg[15:12] <= cmd_byte[3:0];
                  spy_cmd_pkg::OP_LD2: data_reg[11:8]  <= cmd_byte[3:0];
                  spy_cmd_pkg::OP_LD1: data_reg[7:4]   <= cmd_byte[3:0];
                  spy_cmd_pkg::OP_LD0: data_reg[3:0]   <= cmd_byte[3:0];
                  spy_cmd_pkg::OP_RD_LO,
                  spy_cmd_pkg::OP_RD_HI,
                  spy_cmd_pkg::OP_WR_LO,
                  spy_cmd_pkg::OP_WR_HI:
                  begin
                     wb_adr <= {opcode[0], cmd_byte[3:0]};  // odd opcodes hit bank 16..31
                     wb_we  <= is_write;
                     wb_cyc <= 1'b1;
                     wb_stb <= 1'b1;
                     state  <= spy_cmd_pkg::BUS;
                  end
                  default: ;  // ignored opcode
               endcase
            end
            spy_cmd_pkg::BUS:
               if (wb_ack)
               begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
                  state  <= wb_we ? spy_cmd_pkg::IDLE : spy_cmd_pkg::RESPOND;
               end
            default:
               // wait for the transmitter to drain the last answer
               if (!tx_busy)
               begin
                  resp_start <= 1'b1;
                  state      <= spy_cmd_pkg::IDLE;
               end
         endcase
      end

   always_ff @(posedge spy_clk)
   begin
      if (rx_valid && rx_ready)
         cmd_byte <= rx_byte;
      if (state == spy_cmd_pkg::BUS && wb_ack && !wb_we)
         rd_data <= wb_rdata;
      if (state == spy_cmd_pkg::RESPOND && !tx_busy)
         resp_value <= rd_data;  // changes only with resp_start
   end

endmodule

// ==== spy_uart_rx.sv ====
// 8N1 receiver on spy_clk. Holds one byte only and drops a byte that completes while one is held.
`timescale 1ns/100ps
module spy_uart_rx (
   input  logic       spy_clk,
   input  logic       spy_reset,
   input  logic       rxd,
   output logic [7:0] rx_byte,
   output logic       rx_valid,
   input  logic       rx_ready
);
   spy_uart_pkg::uart_state_e state;
   logic [spy_uart_pkg::CNT_W-1:0] cnt;
   logic [2:0] bit_idx;
   logic [7:0] shift;
   logic rxd_s1;
   logic rxd_s2;
   logic rxd_d;
   logic bit_end;
   logic stop_ok;

   assign bit_end = (cnt == spy_uart_pkg::BIT_LAST);
   // good stop bit with room to hold the byte
   assign stop_ok = (state == spy_uart_pkg::U_STOP) && bit_end && rxd_s2 &&
                    (!rx_valid || rx_ready);

   always_ff @(posedge spy_clk)
      if (spy_reset)
      begin
         rxd_s1 <= 1'b1;
         rxd_s2 <= 1'b1;
         rxd_d  <= 1'b1;
      end
      else
      begin
         rxd_s1 <= rxd;
         rxd_s2 <= rxd_s1;
         rxd_d  <= rxd_s2;  // for edge detect
      end

   always_ff @(posedge spy_clk)
      if (spy_reset)
      begin
         state    <= spy_uart_pkg::U_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         if (rx_valid && rx_ready)
            rx_valid <= 1'b0;
         cnt <= cnt + 1'b1;
         case (state)
            spy_uart_pkg::U_IDLE:
            begin
               cnt <= '0;
               if (rxd_d && !rxd_s2)
                  state <= spy_uart_pkg::U_START;
            end
            spy_uart_pkg::U_START:
               if (cnt == spy_uart_pkg::HALF_LAST)
               begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rxd_s2 ? spy_uart_pkg::U_IDLE : spy_uart_pkg::U_DATA;  // glitch
               end
            spy_uart_pkg::U_DATA:
               if (bit_end)
               begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= spy_uart_pkg::U_STOP;
               end
            default:
               if (bit_end)
               begin
                  state <= spy_uart_pkg::U_IDLE;  // mid stop bit, line is high
                  if (stop_ok)
                     rx_valid <= 1'b1;
               end
         endcase
      end

   always_ff @(posedge spy_clk)
   begin
      if (state == spy_uart_pkg::U_DATA && bit_end)
         shift <= {rxd_s2, shift[7:1]};  // lsb first
      if (stop_ok)
         rx_byte <= shift;
   end

endmodule

// ==== spy_uart_pkg.sv ====
// Serial timing for 8N1 framing. BIT_CYCLES must be a power of two of at least 4.
package spy_uart_pkg;

   localparam int BIT_CYCLES = 16;  // spy_clk cycles per bit
   localparam int CNT_W      = $clog2(BIT_CYCLES);
   localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BIT_CYCLES - 1);
   localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CYCLES / 2 - 1);

   typedef enum logic [1:0] {
      U_IDLE  = 2'd0,
      U_START = 2'd1,
      U_DATA  = 2'd2,
      U_STOP  = 2'd3
   } uart_state_e;

endpackage

// ==== spy_cmd_pkg.sv ====
// Command encodings and field widths of the spy port. Opcodes not listed here are ignored.
package spy_cmd_pkg;

   localparam int OPC_W  = 4;
   localparam int DATA_W = 16;  // data register and bus data
   localparam int ADDR_W = 5;   // 32 registers in two banks

   // high nibble of a command byte
   typedef enum logic [OPC_W-1:0] {
      OP_LD3   = 4'h3,  // data[15:12]
      OP_LD2   = 4'h4,
      OP_LD1   = 4'h5,
      OP_LD0   = 4'h6,  // data[3:0]
      OP_RD_LO = 4'h8,
      OP_RD_HI = 4'h9,
      OP_WR_LO = 4'hA,
      OP_WR_HI = 4'hB
   } spy_opcode_e;

   // command engine states
   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      DECODE  = 2'd1,
      BUS     = 2'd2,  // wishbone cycle open
      RESPOND = 2'd3
   } engine_state_e;

endpackage
